// ==== src.f ====
+incdir+hw
hw/pciTargetPkg.sv
hw/cfgSpace.sv
hw/memWaitTimer.sv
hw/sramPort.sv
hw/adOutput.sv
hw/pciTargetFsm.sv
hw/pciTarget.sv
dv/tbClock.sv
dv/pciTarget_tb.sv

// ==== Makefile ====
TOP = pciTarget_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST RESULT: PASS$$"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		--top-module pciTarget -f src.f

clean:
	rm -rf obj_dir

// ==== dv/pciTarget_golden.txt ====
// op(PCI command) addr data cbe(active-low byte enables) idsel burst claim expected, hex
// claim 0 means no DEVSEL# is expected, expected is checked on reads only
A 00000000 00000000 0 1 0 1 80006809 // device, vendor
A 00000008 00000000 0 1 0 1 05000001 // class, revision
A 0000000C 00000000 0 1 0 1 00000000 // header type 0
A 0000002C 00000000 0 1 0 1 80006809 // subsystem ids
A 00000040 00000000 0 1 0 1 00000000 // unimplemented
B 00000010 11223344 8 1 0 1 00000000 // BAR0 top byte masked
A 00000010 00000000 0 1 0 1 F0000000
B 00000010 C0FFFFFF 7 1 0 1 00000000 // move BAR0 to C000_0000
A 00000010 00000000 0 1 0 1 C0000000
B 0000003C 0000005A E 1 0 1 00000000 // interrupt line
B 0000003C 0000EE00 D 1 0 1 00000000 // interrupt pin is read-only
A 0000003C 00000000 0 1 0 1 0000015A
7 C0000010 DEADBEEF 0 0 0 1 00000000
7 C0000010 11223344 A 0 0 1 00000000 // bytes 0 and 2 only
6 C0000010 00000000 0 0 0 1 DE22BE44
7 C0123454 12345678 0 0 0 1 00000000
6 C0123454 00000000 0 0 0 1 12345678
6 F0000010 00000000 0 0 0 0 00000000 // outside BAR0
A 00000000 00000000 0 0 0 0 00000000 // IDSEL low
B 00000004 00000000 E 1 0 1 00000000 // memory enable off
6 C0000010 00000000 0 0 0 0 00000000
B 00000004 00000002 E 1 0 1 00000000 // memory enable on
6 C0000010 00000000 0 0 1 1 DE22BE44 // burst, disconnected

// ==== dv/pciTarget_tb.sv ====
// testbench for the PCI target: replays the golden transaction list as a PCI initiator
// with a behavioral SRAM behind the memory port, checks read data, handshake and parity
`timescale 1ns/100ps
`default_nettype none
`include "pciTarget_config.svh"

module pciTarget_tb import pciTargetPkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 4;
	localparam int FIELDS     = 8;	// words per golden line
	localparam int MAX_TX     = 64;
	localparam int TX_CYCLES  = 16 + `MEM_WAIT_LAST;	// worst case, burst to SRAM
	localparam int SRAM_AW    = 10;	// model depth, low word address bits only

	logic             PCICLK;
	logic             RST_n;
	pciInS            pciIn;
	logic [`AD_W-1:0] memDataIn;
	pciTgtOutS        pciOut;
	sramOutS          sramOut;

	logic [31:0] golden [0:FIELDS*MAX_TX-1];
	logic [31:0] sram [0:(1<<SRAM_AW)-1];
	logic [23:0] lastAdrs;	// word address of the latest SRAM access
	int          numTx;
	int          checkCount;
	int          errorCount;

	tbClock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) i_tbClock (
		.PCICLK(PCICLK), .RST_n(RST_n)
	);

	pciTarget i_pciTarget (
		.PCICLK(PCICLK), .RST_n(RST_n), .pciIn(pciIn), .memDataIn(memDataIn),
		.pciOut(pciOut), .sramOut(sramOut)
	);

	// SRAM model, byte writes under WE# from the driven data bus, read data while OE# low
	assign memDataIn = (!sramOut.ceN && !sramOut.oeN) ? sram[sramOut.adrs[SRAM_AW-1:0]] : '0;

	always @(posedge PCICLK) begin
		if (!sramOut.ceN) begin
			lastAdrs <= sramOut.adrs;
			for (int b = 0; b < 4; b++) begin
				if (!sramOut.weN[b])	// floating data bus stores unknowns
					sram[sramOut.adrs[SRAM_AW-1:0]][8*b +: 8] <=
						sramOut.dataOe ? sramOut.dataOut[8*b +: 8] : 8'hxx;
			end
		end
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// one transaction, single data phase, or a burst that the target disconnects
	task automatic busCycle(input logic [3:0] cmd, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] cbe, input logic idsel, input logic burst,
		input logic claim, input logic [31:0] expected);
		logic isRd;
		logic claimed;
		logic parExp;
		int   waitCnt;
		isRd = (cmd == CMD_CFG_READ) || (cmd == CMD_MEM_READ);
		@(posedge PCICLK);	// address phase
		pciIn.frameN <= 1'b0;
		pciIn.cBeN   <= cmd;
		pciIn.ad     <= addr;
		pciIn.idsel  <= idsel;
		@(posedge PCICLK);	// data phase, held until TRDY#
		pciIn.frameN <= !burst;	// FRAME# high marks the last phase
		pciIn.irdyN  <= 1'b0;
		pciIn.cBeN   <= cbe;
		pciIn.ad     <= isRd ? 32'h0 : data;
		pciIn.idsel  <= 1'b0;
		claimed = 1'b0;
		waitCnt = 0;
		while (!claimed && waitCnt < 5) begin	// master abort after 5 clocks
			@(negedge PCICLK);
			claimed = pciOut.devselOe && !pciOut.devselN;
			waitCnt++;
		end
		checkValue("DEVSEL# claim", 32'(claimed), 32'(claim));
		if (!claimed) begin
			@(posedge PCICLK);
			pciIn.frameN <= 1'b1;
			pciIn.irdyN  <= 1'b1;
			pciIn.cBeN   <= 4'hF;
			repeat (2) @(negedge PCICLK);
			checkValue("devselOe", 32'(pciOut.devselOe), 32'h0);
		end else begin
			while (!(pciOut.trdyOe && !pciOut.trdyN)) @(negedge PCICLK);
			checkValue("STOP#", 32'(pciOut.stopN), 32'h0);	// disconnect with data
			checkValue("stopOe", 32'(pciOut.stopOe), 32'h1);
			checkValue("adOe", 32'(pciOut.adOe), 32'(isRd));	// AD driven on reads only
			if (isRd) checkValue("AD", pciOut.ad, expected);
			parExp = ^{pciOut.ad, pciIn.cBeN};
			@(posedge PCICLK);
			if (!burst) begin
				pciIn.irdyN <= 1'b1;
				pciIn.cBeN  <= 4'hF;
			end
			@(negedge PCICLK);
			if (isRd) begin
				checkValue("PAR", 32'(pciOut.par), 32'(parExp));
				checkValue("parOe", 32'(pciOut.parOe), 32'h1);
			end
			if (burst) begin
				repeat (2) begin	// FRAME# still low, STOP# held, no second TRDY#
					checkValue("TRDY#", 32'(pciOut.trdyN), 32'h1);
					checkValue("STOP#", 32'(pciOut.stopN), 32'h0);
					@(posedge PCICLK);
					@(negedge PCICLK);
				end
				@(posedge PCICLK);
				pciIn.frameN <= 1'b1;	// initiator gives up the burst
				@(posedge PCICLK);
				pciIn.irdyN <= 1'b1;
				pciIn.cBeN  <= 4'hF;
				@(negedge PCICLK);
			end
			checkValue("TRDY#", 32'(pciOut.trdyN), 32'h1);
			checkValue("STOP#", 32'(pciOut.stopN), 32'h1);
			checkValue("DEVSEL#", 32'(pciOut.devselN), 32'h1);
			@(negedge PCICLK);	// turnaround done
			checkValue("devselOe", 32'(pciOut.devselOe), 32'h0);
			checkValue("trdyOe", 32'(pciOut.trdyOe), 32'h0);
			checkValue("stopOe", 32'(pciOut.stopOe), 32'h0);
			checkValue("adOe", 32'(pciOut.adOe), 32'h0);
			if (cmd == CMD_MEM_READ || cmd == CMD_MEM_WRITE)
				checkValue("SRAM adrs", 32'(lastAdrs), {10'h000, addr[23:2]});
		end
	endtask

	initial begin
		int line;
		pciIn <= '{frameN: 1'b1, irdyN: 1'b1, cBeN: 4'hF, ad: '0, idsel: 1'b0};
		checkCount = 0;
		errorCount = 0;
		for (int i = 0; i < FIELDS*MAX_TX; i++) golden[i] = '1;	// all ones ends the list
		$readmemh("dv/pciTarget_golden.txt", golden);
		numTx = 0;
		while (numTx < MAX_TX && golden[FIELDS*numTx] != '1) numTx++;
		wait (RST_n === 1'b1);
		for (line = 0; line < numTx; line++) begin
			busCycle(golden[FIELDS*line][3:0], golden[FIELDS*line+1], golden[FIELDS*line+2],
				golden[FIELDS*line+3][3:0], golden[FIELDS*line+4][0], golden[FIELDS*line+5][0],
				golden[FIELDS*line+6][0], golden[FIELDS*line+7]);
		end
		repeat (2) @(posedge PCICLK);
		$display("%0d transactions, %0d checks, %0d errors", numTx, checkCount, errorCount);
		if (errorCount == 0 && numTx != 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			if (numTx == 0) $display("no transactions could be read from the golden file");
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// watchdog, sized from the transaction count
	initial begin
		wait (numTx != 0);
		#((RST_CYCLES + numTx * TX_CYCLES) * CLK_PERIOD);
		$display("watchdog expired before all bus transactions completed");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tbClock.sv ====
// testbench clock and power-on reset for the PCI target
// RST_n is released on a rising edge after RST_CYCLES clocks
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
	parameter int PERIOD     = 40,	// ns
	parameter int RST_CYCLES = 4
) (
	output logic PCICLK,
	output logic RST_n
);

	initial begin
		PCICLK = 1'b0;
		forever #(PERIOD / 2) PCICLK = ~PCICLK;
	end

	initial begin
		RST_n = 1'b0;
		repeat (RST_CYCLES) @(posedge PCICLK);
		RST_n <= 1'b1;	// released on an edge like every other input
	end

endmodule

`default_nettype wire

// ==== hw/pciTarget.sv ====
// PCI target top: config space plus an SRAM window behind BAR0, one data phase per access
// pads live on the board level, every output comes as value plus enable
`timescale 1ns/100ps
`default_nettype none
`include "pciTarget_config.svh"

module pciTarget import pciTargetPkg::*; (
	input  wire                    PCICLK,
	input  wire                    RST_n,
	input  wire pciInS             pciIn,
	input  wire [`AD_W-1:0]        memDataIn,
	output pciTgtOutS              pciOut,
	output sramOutS                sramOut
);

	addrPhaseS             addrPhase;	// latched command, address, idsel
	logic                  hitCfg;
	logic                  hitMem;
	logic                  accessStart;	// one-cycle start strobe
	logic                  memLast;
	logic [`MEM_CNT_W-1:0] count;
	logic [`AD_W-1:0]      cfgRdData;
	logic [`AD_W-1:0]      sramRdData;
	logic [`AD_W-1:0]      ad;
	logic                  adOe;
	logic                  par;
	logic                  parOe;
	logic                  devselN;
	logic                  devselOe;
	logic                  trdyN;
	logic                  trdyOe;
	logic                  stopN;
	logic                  stopOe;

	assign pciOut = '{ad: ad, adOe: adOe, par: par, parOe: parOe,
		devselN: devselN, devselOe: devselOe, trdyN: trdyN, trdyOe: trdyOe,
		stopN: stopN, stopOe: stopOe};

	pciTargetFsm i_pciTargetFsm (
		.PCICLK(PCICLK), .RST_n(RST_n), .pciIn(pciIn),
		.hitCfg(hitCfg), .hitMem(hitMem), .memLast(memLast),
		.addrPhase(addrPhase), .accessStart(accessStart), .isRead(),
		.devselN(devselN), .devselOe(devselOe), .trdyN(trdyN), .trdyOe(trdyOe),
		.stopN(stopN), .stopOe(stopOe), .adOe(adOe)
	);

	cfgSpace i_cfgSpace (
		.PCICLK(PCICLK), .RST_n(RST_n), .pciIn(pciIn), .addrPhase(addrPhase),
		.accessStart(accessStart), .hitCfg(hitCfg), .hitMem(hitMem), .cfgRdData(cfgRdData)
	);

	memWaitTimer i_memWaitTimer (
		.PCICLK(PCICLK), .RST_n(RST_n), .accessStart(accessStart), .hitMem(hitMem),
		.count(count), .memLast(memLast)
	);

	sramPort i_sramPort (
		.PCICLK(PCICLK), .RST_n(RST_n), .pciIn(pciIn), .addrPhase(addrPhase),
		.count(count), .memLast(memLast), .memDataIn(memDataIn),
		.sramOut(sramOut), .sramRdData(sramRdData)
	);

	adOutput i_adOutput (
		.PCICLK(PCICLK), .RST_n(RST_n), .pciIn(pciIn), .hitCfg(hitCfg),
		.accessStart(accessStart), .memLast(memLast), .cfgRdData(cfgRdData),
		.sramRdData(sramRdData), .adOe(adOe), .ad(ad), .par(par), .parOe(parOe)
	);

endmodule

`default_nettype wire

// ==== hw/pciTargetFsm.sv ====
// target FSM: address phase latch, hit/miss, IRDY# wait, access, TRDY# and disconnect
// also tracks other targets' transactions until the bus goes idle
`timescale 1ns/100ps
`default_nettype none

module pciTargetFsm import pciTargetPkg::*; (
	input  wire        PCICLK,
	input  wire        RST_n,
	input  wire pciInS pciIn,
	input  wire        hitCfg,
	input  wire        hitMem,
	input  wire        memLast,
	output addrPhaseS  addrPhase,
	output logic       accessStart,
	output logic       isRead,
	output logic       devselN,
	output logic       devselOe,
	output logic       trdyN,
	output logic       trdyOe,
	output logic       stopN,
	output logic       stopOe,
	output logic       adOe
);

	tgtStateE state;
	logic     addrValid;	// FRAME# just fell, IRDY# still high
	logic     ack;			// local side has the data

	assign addrValid = !pciIn.frameN && pciIn.irdyN;
	assign isRead = (addrPhase.cmd == CMD_CFG_READ) || (addrPhase.cmd == CMD_MEM_READ);
	assign ack = (accessStart && hitCfg) || memLast;	// config answers in the strobe cycle

	always_ff @(posedge PCICLK) begin
		if (state == IDLE && addrValid) begin
			addrPhase <= '{cmd: pciCmdE'(pciIn.cBeN), adrs: pciIn.ad, idsel: pciIn.idsel};
		end
	end

	always_ff @(posedge PCICLK or negedge RST_n) begin
		if (!RST_n) begin
			state       <= IDLE;
			accessStart <= 1'b0;
			adOe        <= 1'b0;
			devselN     <= 1'b1;
			devselOe    <= 1'b0;
			trdyN       <= 1'b1;
			trdyOe      <= 1'b0;
			stopN       <= 1'b1;
			stopOe      <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (addrValid) state <= ADRS_COMPARE;
				end
				ADRS_COMPARE: begin
					if (hitCfg || hitMem) begin
						devselN  <= 1'b0;	// claim it
						devselOe <= 1'b1;
						trdyOe   <= 1'b1;	// TRDY#, STOP# driven high
						stopOe   <= 1'b1;
						state    <= WAIT_IRDY;
					end else begin
						state <= BUS_BUSY;
					end
				end
				BUS_BUSY: begin
					if (pciIn.frameN && pciIn.irdyN) state <= IDLE;	// bus idle again
				end
				WAIT_IRDY: begin
					if (!pciIn.irdyN) begin
						accessStart <= 1'b1;
						adOe        <= isRead;	// turn AD around on reads
						state       <= ACCESS;
					end
				end
				ACCESS: begin
					accessStart <= 1'b0;
					if (ack) begin
						trdyN <= 1'b0;
						stopN <= 1'b0;	// cut any burst after this phase
						state <= ACC_COMPLETE;
					end
				end
				ACC_COMPLETE: begin
					trdyN <= 1'b1;
					adOe  <= 1'b0;
					if (!pciIn.frameN) begin
						state <= DISCONNECT;	// burst, hold STOP#
					end else begin
						devselN <= 1'b1;
						stopN   <= 1'b1;
						state   <= TURN_AROUND;
					end
				end
				DISCONNECT: begin
					if (pciIn.frameN) begin	// initiator saw STOP#
						devselN <= 1'b1;
						stopN   <= 1'b1;
						state   <= TURN_AROUND;
					end
				end
				TURN_AROUND: begin
					devselOe <= 1'b0;
					trdyOe   <= 1'b0;
					stopOe   <= 1'b0;
					state    <= IDLE;
				end
				default: state <= TURN_AROUND;
			endcase
		end
	end

	// data phase only inside a claimed transaction
	assert property (@(posedge PCICLK) disable iff (!RST_n)
		(trdyOe && !trdyN) |-> (devselOe && !devselN))
		else $error("TRDY# low without DEVSEL#");

endmodule

`default_nettype wire

// ==== hw/adOutput.sv ====
// AD read-data register and target parity
// PAR covers the driven AD and C/BE# and trails them by one clock
`timescale 1ns/100ps
`default_nettype none
`include "pciTarget_config.svh"

module adOutput import pciTargetPkg::*; (
	input  wire                PCICLK,
	input  wire                RST_n,
	input  wire pciInS         pciIn,
	input  wire                hitCfg,
	input  wire                accessStart,
	input  wire                memLast,
	input  wire [`AD_W-1:0]    cfgRdData,
	input  wire [`AD_W-1:0]    sramRdData,
	input  wire                adOe,
	output logic [`AD_W-1:0]   ad,
	output logic               par,
	output logic               parOe
);

	always_ff @(posedge PCICLK) begin
		if (accessStart && hitCfg) ad <= cfgRdData;	// config word ready at once
		else if (memLast) ad <= sramRdData;			// SRAM word at end of wait
	end

	always_ff @(posedge PCICLK or negedge RST_n) begin
		if (!RST_n) begin
			par   <= 1'b0;
			parOe <= 1'b0;
		end else begin
			parOe <= adOe;
			par   <= ^{ad, pciIn.cBeN};	// even parity, one clock late
		end
	end

endmodule

`default_nettype wire

// ==== hw/sramPort.sv ====
// SRAM side of a memory access, strobes sequenced by the wait count
// word address from AD[23:2], byte lanes written from C/BE#
`timescale 1ns/100ps
`default_nettype none
`include "pciTarget_config.svh"

module sramPort import pciTargetPkg::*; (
	input  wire                    PCICLK,
	input  wire                    RST_n,
	input  wire pciInS             pciIn,
	input  wire addrPhaseS         addrPhase,
	input  wire [`MEM_CNT_W-1:0]   count,
	input  wire                    memLast,
	input  wire [`AD_W-1:0]        memDataIn,
	output sramOutS                sramOut,
	output logic [`AD_W-1:0]       sramRdData
);

	localparam logic [`MEM_CNT_W-1:0] CNT_FIRST  = '0;
	localparam logic [`MEM_CNT_W-1:0] CNT_OE     = `MEM_OE_COUNT;
	localparam logic [`MEM_CNT_W-1:0] CNT_SAMPLE = `MEM_WAIT_LAST - 1;

	logic             memWrite;
	logic             ceN;
	logic             oeN;
	logic [3:0]       weN;
	logic             dataOe;
	logic [`AD_W-1:0] dataOut;

	assign memWrite = (addrPhase.cmd == CMD_MEM_WRITE);

	always_comb begin
		sramOut.adrs    = {2'b00, addrPhase.adrs[23:2]};
		sramOut.dataOut = dataOut;
		sramOut.dataOe  = dataOe;
		sramOut.ceN     = ceN;
		sramOut.oeN     = oeN;
		sramOut.weN     = weN;
	end

	always_ff @(posedge PCICLK or negedge RST_n) begin
		if (!RST_n) begin
			ceN    <= 1'b1;
			oeN    <= 1'b1;
			weN    <= 4'hF;
			dataOe <= 1'b0;
		end else if (memLast) begin
			ceN    <= 1'b1;	// release everything
			oeN    <= 1'b1;
			weN    <= 4'hF;
			dataOe <= 1'b0;
		end else if (count == CNT_FIRST) begin
			ceN    <= 1'b0;
			dataOe <= memWrite;	// drive data bus on writes only
		end else if (count == CNT_OE) begin
			if (memWrite) weN <= pciIn.cBeN;	// held by initiator until TRDY#
			else oeN <= 1'b0;
		end
	end

	always_ff @(posedge PCICLK) begin
		if (count == CNT_FIRST) dataOut <= pciIn.ad;
		// sampled on the edge into the last count, steady while memLast is high
		if (count == CNT_SAMPLE && !memWrite) sramRdData <= memDataIn;
	end

	assert property (@(posedge PCICLK) disable iff (!RST_n)
		!(!sramOut.oeN && sramOut.weN != 4'hF))
		else $error("SRAM OE# and WE# low together");

endmodule

`default_nettype wire

// ==== hw/memWaitTimer.sv ====
// wait counter for one SRAM access, count 0 is the start-strobe cycle
// memLast marks the final count, after which the counter parks at idle
`timescale 1ns/100ps
`default_nettype none
`include "pciTarget_config.svh"

module memWaitTimer (
	input  wire                    PCICLK,
	input  wire                    RST_n,
	input  wire                    accessStart,
	input  wire                    hitMem,
	output logic [`MEM_CNT_W-1:0]  count,
	output logic                   memLast
);

	localparam logic [`MEM_CNT_W-1:0] CNT_IDLE = '1;	// outside 0..last
	localparam logic [`MEM_CNT_W-1:0] CNT_LAST = `MEM_WAIT_LAST;

	logic [`MEM_CNT_W-1:0] cntReg;	// count for the next cycle

	assign count = (accessStart && hitMem) ? '0 : cntReg;
	assign memLast = (count == CNT_LAST);

	always_ff @(posedge PCICLK or negedge RST_n) begin
		if (!RST_n) begin
			cntReg <= CNT_IDLE;
		end else if (count == CNT_IDLE || memLast) begin
			cntReg <= CNT_IDLE;
		end else begin
			cntReg <= count + 1'b1;
		end
	end

	assert property (@(posedge PCICLK) disable iff (!RST_n)
		(cntReg != CNT_IDLE) |-> !accessStart)
		else $error("SRAM access restarted while counting");

endmodule

`default_nettype wire

// ==== hw/cfgSpace.sv ====
// type-0 configuration header and address decode for config and BAR0 memory hits
// writes land on the start strobe, read word is formed from the latched offset
`timescale 1ns/100ps
`default_nettype none
`include "pciTarget_config.svh"

module cfgSpace import pciTargetPkg::*; (
	input  wire                   PCICLK,
	input  wire                   RST_n,
	input  wire pciInS            pciIn,
	input  wire addrPhaseS        addrPhase,
	input  wire                   accessStart,
	output logic                  hitCfg,
	output logic                  hitMem,
	output logic [`AD_W-1:0]      cfgRdData
);

	localparam logic [5:0] OFS_ID     = 6'h00;
	localparam logic [5:0] OFS_CMD    = 6'h01;	// command/status
	localparam logic [5:0] OFS_CLASS  = 6'h02;
	localparam logic [5:0] OFS_HDR    = 6'h03;
	localparam logic [5:0] OFS_BAR0   = 6'h04;
	localparam logic [5:0] OFS_SUBSYS = 6'h0B;
	localparam logic [5:0] OFS_INT    = 6'h0F;

	logic       memEn;		// command bit 1
	logic [7:0] bar0;		// BAR0[31:24], 16 MB window
	logic [7:0] intLine;
	logic [5:0] regIdx;		// dword offset
	logic       cfgWrite;

	assign regIdx = addrPhase.adrs[7:2];

	// IDSEL, function 0, type 0
	assign hitCfg = (addrPhase.cmd inside {CMD_CFG_READ, CMD_CFG_WRITE}) && addrPhase.idsel
		&& (addrPhase.adrs[10:8] == 3'b000) && (addrPhase.adrs[1:0] == 2'b00);
	assign hitMem = (addrPhase.cmd inside {CMD_MEM_READ, CMD_MEM_WRITE})
		&& (addrPhase.adrs[31:24] == bar0) && memEn;

	assign cfgWrite = accessStart && hitCfg && (addrPhase.cmd == CMD_CFG_WRITE);

	always_ff @(posedge PCICLK or negedge RST_n) begin
		if (!RST_n) begin
			memEn   <= `MEM_EN_RESET;
			bar0    <= `BAR0_RESET;
			intLine <= 8'h00;
		end else if (cfgWrite) begin
			case (regIdx)
				OFS_CMD:  if (!pciIn.cBeN[0]) memEn <= pciIn.ad[1];
				OFS_BAR0: if (!pciIn.cBeN[3]) bar0 <= pciIn.ad[31:24];
				OFS_INT:  if (!pciIn.cBeN[0]) intLine <= pciIn.ad[7:0];
				default: ;	// read-only or unimplemented
			endcase
		end
	end

	always_comb begin
		case (regIdx)
			OFS_ID:     cfgRdData = {`CFG_DEVICE_ID, `CFG_VENDOR_ID};
			OFS_CMD:    cfgRdData = {`CFG_STATUS, 14'h0000, memEn, 1'b0};
			OFS_CLASS:  cfgRdData = {`CFG_CLASS, 16'h0000, `CFG_REVISION};
			OFS_HDR:    cfgRdData = {8'h00, `CFG_HEADER_TYPE, 16'h0000};
			OFS_BAR0:   cfgRdData = {bar0, 24'h000000};	// 32-bit memory BAR
			OFS_SUBSYS: cfgRdData = {`CFG_DEVICE_ID, `CFG_VENDOR_ID};
			OFS_INT:    cfgRdData = {16'h0000, `CFG_INT_PIN, intLine};
			default:    cfgRdData = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/pciTargetPkg.sv ====
// shared types of the PCI target: bus commands, FSM states and the bundled bus signals
// modules pull these in with a wildcard import in their header
`default_nettype none
`include "pciTarget_config.svh"

package pciTargetPkg;

	typedef enum logic [3:0] {
		CMD_INT_ACK   = 4'b0000,
		CMD_IO_READ   = 4'b0010,	// no I/O space here, never claimed
		CMD_IO_WRITE  = 4'b0011,
		CMD_MEM_READ  = 4'b0110,
		CMD_MEM_WRITE = 4'b0111,
		CMD_CFG_READ  = 4'b1010,
		CMD_CFG_WRITE = 4'b1011
	} pciCmdE;

	typedef enum logic [2:0] {
		IDLE         = 3'd0,
		ADRS_COMPARE = 3'd1,
		BUS_BUSY     = 3'd2,	// someone else's transaction
		WAIT_IRDY    = 3'd3,
		ACCESS       = 3'd4,
		ACC_COMPLETE = 3'd5,
		DISCONNECT   = 3'd6,
		TURN_AROUND  = 3'd7
	} tgtStateE;

	typedef struct packed {
		logic             frameN;
		logic             irdyN;
		logic [3:0]       cBeN;		// command in address phase, byte enables after
		logic [`AD_W-1:0] ad;
		logic             idsel;
	} pciInS;

	typedef struct packed {
		logic [`AD_W-1:0] ad;
		logic             adOe;
		logic             par;
		logic             parOe;
		logic             devselN;
		logic             devselOe;
		logic             trdyN;
		logic             trdyOe;
		logic             stopN;
		logic             stopOe;
	} pciTgtOutS;

	typedef struct packed {
		logic [`MEM_ADRS_W-1:0] adrs;	// word address
		logic [`AD_W-1:0]       dataOut;
		logic                   dataOe;
		logic                   ceN;
		logic                   oeN;
		logic [3:0]             weN;	// one per byte lane
	} sramOutS;

	typedef struct packed {
		pciCmdE           cmd;
		logic [`AD_W-1:0] adrs;
		logic             idsel;
	} addrPhaseS;

endpackage

`default_nettype wire

// ==== hw/pciTarget_config.svh ====
// fixed type-0 header values, register reset values, SRAM wait counts and bus widths
// include wherever one of these macros is needed
`ifndef PCITARGET_CONFIG_SVH
`define PCITARGET_CONFIG_SVH

`define CFG_VENDOR_ID	16'h6809	// vendor id, also subsystem vendor
`define CFG_DEVICE_ID	16'h8000	// device id, also subsystem id
`define CFG_CLASS		8'h05		// memory controller
`define CFG_REVISION	8'h01
`define CFG_HEADER_TYPE	8'h00		// single function, type 0
`define CFG_INT_PIN		8'h01		// INTA#
`define CFG_STATUS		16'h0200	// medium devsel timing

`define BAR0_RESET		8'hF0		// window at F000_0000h after reset
`define MEM_EN_RESET	1'b1		// memory space on after reset

`define MEM_WAIT_LAST	4			// SRAM access done in this count
`define MEM_OE_COUNT	1			// strobes start here
`define MEM_CNT_W		3			// wait counter width, all ones is idle

`define AD_W			32
`define MEM_ADRS_W		24

`endif
